// ==== logic/lz_copy_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module lz_copy_engine #(
   parameter int HIST_DEPTH = 256
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      cmd_valid,
   input  lz_stream_pkg::copy_cmd_t  cmd,
   output logic                      cmd_ready,
   output logic                      beat_valid,
   output lz_stream_pkg::byte_beat_t beat,
   input  logic                      beat_ready
);

   localparam int PTR_W = $clog2(HIST_DEPTH);

   logic [7:0]                      hist [HIST_DEPTH];
   logic [PTR_W-1:0]                wr_ptr;
   logic [PTR_W-1:0]                rd_ptr;
   logic                            busy;   // a match still has bytes to emit.
   logic [4:0]                      rem;
   logic [lz_token_pkg::DIST_W-1:0] dist_q;
   logic                            bad_q;
   logic                            last_q;
   logic                            load_en;
   logic                            cmd_take;
   logic                            emit;
   logic                            src_match;
   logic [lz_token_pkg::DIST_W-1:0] src_dist;
   lz_stream_pkg::byte_beat_t       beat_next;

   assign load_en   = !beat_valid || beat_ready;
   assign cmd_ready = load_en && !busy;
   assign cmd_take  = cmd_valid && cmd_ready;
   assign emit      = load_en && (busy || cmd_valid);

   always_comb begin
      src_match = busy || cmd.is_match;
      src_dist  = busy ? dist_q : cmd.distance;
      rd_ptr    = wr_ptr - PTR_W'(src_dist);  // distance HIST_DEPTH lands on the oldest byte.
      if (busy) begin
         beat_next.err_dist = bad_q;
         beat_next.last     = last_q && (rem == 5'd1);
      end else begin
         beat_next.err_dist = cmd.bad_dist;
         beat_next.last     = cmd.last && !cmd.is_match;  // a match is never done on its first byte.
      end
      if (!src_match) begin
         beat_next.data = cmd.lit_byte;
      end else if (beat_next.err_dist) begin
         beat_next.data = 8'h00;
      end else begin
         beat_next.data = hist[rd_ptr];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beat_valid <= 1'b0;
         busy       <= 1'b0;
         wr_ptr     <= '0;
      end else begin
         if (emit) begin
            beat_valid <= 1'b1;
            wr_ptr     <= wr_ptr + 1'b1;
         end else if (beat_ready) begin
            beat_valid <= 1'b0;
         end
         if (cmd_take && cmd.is_match) begin
            busy <= 1'b1;
         end else if (busy && load_en && rem == 5'd1) begin
            busy <= 1'b0;
         end
      end
   end

   // each byte enters the history as it is emitted, so overlapping copies see it next cycle.
   always_ff @(posedge clk) begin
      if (emit) begin
         hist[wr_ptr] <= beat_next.data;
         beat         <= beat_next;
      end
      if (cmd_take) begin
         rem    <= cmd.length - 5'd1;
         dist_q <= cmd.distance;
         bad_q  <= cmd.bad_dist;
         last_q <= cmd.last;
      end else if (busy && load_en) begin
         rem <= rem - 5'd1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/lz_decomp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lz_decomp_top #(
   parameter int HIST_DEPTH = 256  // power of two, 16 to 2048.
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              token_valid,
   output logic                              token_ready,
   input  lz_token_pkg::token_beat_t         token,
   output logic                              out_valid,
   input  logic                              out_ready,
   output logic [7:0]                        out_byte,
   input  logic [lz_stream_pkg::COUNT_W-1:0] frame_limit,
   output logic                              status_valid,
   output lz_stream_pkg::frame_status_t      status
);

   logic                      cmd_valid;
   logic                      cmd_ready;
   lz_stream_pkg::copy_cmd_t  cmd;
   logic                      beat_valid;
   logic                      beat_ready;
   lz_stream_pkg::byte_beat_t beat;

   lz_token_decode #(.HIST_DEPTH(HIST_DEPTH)) u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .token_valid (token_valid),
      .token       (token),
      .token_ready (token_ready),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .cmd_ready   (cmd_ready)
   );

   lz_copy_engine #(.HIST_DEPTH(HIST_DEPTH)) u_copy (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_ready  (cmd_ready),
      .beat_valid (beat_valid),
      .beat       (beat),
      .beat_ready (beat_ready)
   );

   lz_out_framer u_framer (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat_valid   (beat_valid),
      .beat         (beat),
      .beat_ready   (beat_ready),
      .frame_limit  (frame_limit),
      .out_valid    (out_valid),
      .out_byte     (out_byte),
      .out_ready    (out_ready),
      .status_valid (status_valid),
      .status       (status)
   );

endmodule

`default_nettype wire

// ==== logic/lz_out_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lz_out_framer (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                beat_valid,
   input  lz_stream_pkg::byte_beat_t           beat,
   output logic                                beat_ready,
   input  logic [lz_stream_pkg::COUNT_W-1:0]   frame_limit,
   output logic                                out_valid,
   output logic [7:0]                          out_byte,
   input  logic                                out_ready,
   output logic                                status_valid,
   output lz_stream_pkg::frame_status_t        status
);

   logic [lz_stream_pkg::COUNT_W-1:0] byte_cnt;  // index of the next byte in the frame.
   logic [lz_stream_pkg::COUNT_W-1:0] limit_q;
   logic [lz_stream_pkg::COUNT_W-1:0] limit_eff;
   logic                              in_frame;
   logic                              err_dist_acc;
   logic                              err_limit_acc;
   logic                              take;
   logic                              fwd;

   assign beat_ready = !out_valid || out_ready;
   assign take       = beat_valid && beat_ready;
   assign limit_eff  = in_frame ? limit_q : frame_limit;
   assign fwd        = byte_cnt < limit_eff;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid     <= 1'b0;
         status_valid  <= 1'b0;
         byte_cnt      <= '0;
         in_frame      <= 1'b0;
         err_dist_acc  <= 1'b0;
         err_limit_acc <= 1'b0;
      end else begin
         status_valid <= take && beat.last;
         if (take && fwd) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
         if (take) begin
            if (beat.last) begin
               byte_cnt      <= '0;
               in_frame      <= 1'b0;
               err_dist_acc  <= 1'b0;
               err_limit_acc <= 1'b0;
            end else begin
               byte_cnt      <= byte_cnt + 1'b1;
               in_frame      <= 1'b1;
               err_dist_acc  <= err_dist_acc || beat.err_dist;
               err_limit_acc <= err_limit_acc || !fwd;  // bytes past the limit are swallowed.
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take && fwd) begin
         out_byte <= beat.data;
      end
      if (take && !in_frame) begin
         limit_q <= frame_limit;
      end
      if (take && beat.last) begin
         status.byte_count <= byte_cnt + 1'b1;
         status.err_dist   <= err_dist_acc || beat.err_dist;
         status.err_limit  <= err_limit_acc || !fwd;
      end
   end

endmodule

`default_nettype wire

// ==== logic/lz_stream_pkg.sv ====
`default_nettype none

package lz_stream_pkg;

   localparam int COUNT_W = 16;

   // command passed from the token decoder to the copy engine.
   typedef struct packed {
      logic                            is_match;
      logic [7:0]                      lit_byte;
      logic [4:0]                      length;    // 1 for a literal.
      logic [lz_token_pkg::DIST_W-1:0] distance;
      logic                            bad_dist;  // distance reaches outside the frame history.
      logic                            last;
   } copy_cmd_t;

   // one decoded byte on its way to the framer.
   typedef struct packed {
      logic [7:0] data;
      logic       last;
      logic       err_dist;
   } byte_beat_t;

   // end of frame report.
   typedef struct packed {
      logic [COUNT_W-1:0] byte_count;  // counts dropped bytes as well.
      logic               err_dist;
      logic               err_limit;
   } frame_status_t;

endpackage

`default_nettype wire

// ==== logic/lz_token_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module lz_token_decode #(
   parameter int HIST_DEPTH = 256
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      token_valid,
   input  lz_token_pkg::token_beat_t token,
   output logic                      token_ready,
   output logic                      cmd_valid,
   output lz_stream_pkg::copy_cmd_t  cmd,
   input  logic                      cmd_ready
);

   localparam int CNT_W = $clog2(HIST_DEPTH) + 1;
   localparam int SUM_W = CNT_W + 1;
   localparam int CMP_W = lz_token_pkg::DIST_W + 1;

   logic [CNT_W-1:0]         frame_cnt;  // bytes produced so far in this frame.
   logic [SUM_W-1:0]         cnt_sum;
   logic                     token_take;
   lz_stream_pkg::copy_cmd_t cmd_next;

   assign token_ready = !cmd_valid || cmd_ready;
   assign token_take  = token_valid && token_ready;

   always_comb begin
      cmd_next          = '0;
      cmd_next.is_match = token.token.match.is_match;
      cmd_next.lit_byte = token.token.lit.lit_byte;
      cmd_next.distance = token.token.match.distance;
      cmd_next.last     = token.last;
      if (cmd_next.is_match) begin
         cmd_next.length   = 5'(token.token.match.len_code) + 5'(lz_token_pkg::MATCH_MIN);
         cmd_next.bad_dist = (token.token.match.distance == '0) ||
                             (CMP_W'(token.token.match.distance) > CMP_W'(frame_cnt));
      end else begin
         cmd_next.length = 5'd1;
      end
   end

   assign cnt_sum = {1'b0, frame_cnt} + SUM_W'(cmd_next.length);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_valid <= 1'b0;
         frame_cnt <= '0;
      end else begin
         if (token_take) begin
            cmd_valid <= 1'b1;
            if (token.last) begin
               frame_cnt <= '0;  // the next frame starts with no usable history.
            end else if (cnt_sum > SUM_W'(HIST_DEPTH)) begin
               frame_cnt <= CNT_W'(HIST_DEPTH);
            end else begin
               frame_cnt <= cnt_sum[CNT_W-1:0];
            end
         end else if (cmd_ready) begin
            cmd_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (token_take) begin
         cmd <= cmd_next;
      end
   end

endmodule

`default_nettype wire

// ==== logic/lz_token_pkg.sv ====
`default_nettype none

package lz_token_pkg;

   localparam int TOKEN_W   = 16;
   localparam int DIST_W    = 11;
   localparam int LEN_W     = 4;
   localparam int MATCH_MIN = 3;  // a length code of 0 means a 3 byte match.

   // literal view of a token word.
   typedef struct packed {
      logic       is_match;  // always 0 in this view.
      logic [6:0] rsvd;
      logic [7:0] lit_byte;
   } token_lit_t;

   // match view of a token word.
   typedef struct packed {
      logic              is_match;  // always 1 in this view.
      logic [LEN_W-1:0]  len_code;
      logic [DIST_W-1:0] distance;
   } token_match_t;

   // the top bit selects which view holds, so both views keep it in the same place.
   typedef union packed {
      token_lit_t   lit;
      token_match_t match;
   } token_u;

   typedef struct packed {
      token_u token;
      logic   last;  // final token of the frame.
   } token_beat_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_lz_decomp \
   -f sources.f -o tb_lz_decomp

sim_out=$(./obj_dir/tb_lz_decomp 2>&1) || true
echo "$sim_out"

if grep -qx "NO ERRORS" <<< "$sim_out"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== sources.f ====
logic/lz_token_pkg.sv
logic/lz_stream_pkg.sv
logic/lz_token_decode.sv
logic/lz_copy_engine.sv
logic/lz_out_framer.sv
logic/lz_decomp_top.sv
test/lz_decomp_assert.sv
test/tb_lz_decomp.sv

// ==== test/lz_decomp_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module lz_decomp_assert (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      busy,
   input  logic [4:0]                rem,
   input  logic                      cmd_ready,
   input  logic                      beat_valid,
   input  logic                      beat_ready,
   input  lz_stream_pkg::byte_beat_t beat
);

   // a stalled beat has to wait unchanged for the framer.
   assert property (@(posedge clk) disable iff (!rst_n)
      beat_valid && !beat_ready |=> beat_valid && $stable(beat))
      else $error("copy engine changed or dropped a stalled beat");

   // a match keeps the next command waiting until its final byte goes out.
   assert property (@(posedge clk) disable iff (!rst_n)
      busy && rem != 5'd1 |=> !cmd_ready)
      else $error("copy engine was ready while match bytes remained");

   assert property (@(posedge clk) !rst_n |=> !beat_valid)
      else $error("beat_valid was high after a reset cycle");

endmodule

bind lz_copy_engine lz_decomp_assert u_copy_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .busy       (busy),
   .rem        (rem),
   .cmd_ready  (cmd_ready),
   .beat_valid (beat_valid),
   .beat_ready (beat_ready),
   .beat       (beat)
);

`default_nettype wire

// ==== test/lz_decomp_input.txt ====
// one hex word per record: 1000LLLL frame limit, 200LTTTT token (L = last flag),
// 300000BB expected output byte, 40DLCCCC expected status (D = err_dist, L = err_limit,
// CCCC = decoded byte count). a zero word or the end of the file ends the list.
// literals only
10000040
20000048 20000065 2000006C 2000006C 2001006F
30000048 30000065 3000006C 3000006C 3000006F
40000005
// run of 18 at distance 1, then an overlapping copy of 7 at distance 3
20000041 2000F801 20000031 20000032 20000033 2001A003
30000041 30000041 30000041 30000041 30000041 30000041 30000041 30000041 30000041 30000041
30000041 30000041 30000041 30000041 30000041 30000041 30000041 30000041 30000041
30000031 30000032 30000033 30000031 30000032 30000033 30000031 30000032 30000033 30000031
4000001D
// distance 0, then distance 9 with only 5 bytes produced
20000010 20000011 20008000 20008009 20010012
30000010 30000011 30000000 30000000 30000000 30000000 30000000 30000000 30000012
40100009
// the following frame reports clean
20000055 20010066
30000055 30000066
40000002
// distance 4 reaches behind the frame start into older history
20000077 20018004
30000077 30000000 30000000 30000000
40100004
// seven decoded bytes against a limit of four
10000004
200000A0 200000A1 200000A2 20018803
300000A0 300000A1 300000A2 300000A0
40010007
// limit restored
10000040
2001005A
3000005A
40000001

// ==== test/tb_lz_decomp.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lz_decomp;

   localparam int MAX_RECS = 256;

   logic                              clk;
   logic                              rst_n;
   logic                              token_valid;
   logic                              token_ready;
   lz_token_pkg::token_beat_t         token;
   logic                              out_valid;
   logic                              out_ready;
   logic [7:0]                        out_byte;
   logic [lz_stream_pkg::COUNT_W-1:0] frame_limit;
   logic                              status_valid;
   lz_stream_pkg::frame_status_t      status;

   logic [31:0] recs [MAX_RECS];
   int          n_recs;
   int          wd_cycles;
   logic [31:0] lfsr_state;
   logic        stalls_on;
   logic        gap;          // hold the next token back this cycle.
   int          stat_seen;
   int          stat_target;
   logic [17:0] exp_st;
   logic [7:0]  exp_bytes [$];
   logic [17:0] exp_status [$];  // {byte_count, err_dist, err_limit}.

   lz_decomp_top #(.HIST_DEPTH(256)) DUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .token_valid  (token_valid),
      .token_ready  (token_ready),
      .token        (token),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_byte     (out_byte),
      .frame_limit  (frame_limit),
      .status_valid (status_valid),
      .status       (status)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic take_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   task automatic report_failure();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s was %h, expected %h", $time, what, got, exp);
         report_failure();
      end
   endtask

   // inputs change 1 ns after the rising edge.
   task automatic step_cycle();
      logic b0;
      logic b1;
      @(posedge clk);
      #1;
      if (stalls_on) begin
         b0        = take_bit();
         b1        = take_bit();
         out_ready = !(b0 && b1);
         gap       = take_bit();
      end else begin
         out_ready = 1'b1;
         gap       = 1'b0;
      end
   endtask

   task automatic send_token(input logic [31:0] rec);
      logic done;
      done = 1'b0;
      while (gap) begin
         step_cycle();
      end
      token_valid = 1'b1;
      token       = {rec[15:0], rec[16]};
      while (!done) begin
         @(negedge clk);
         done = token_ready;  // inputs are settled by now, so this edge transfers it.
         step_cycle();
      end
      token_valid = 1'b0;
   endtask

   task automatic load_expected();
      int i;
      exp_bytes.delete();
      exp_status.delete();
      for (i = 0; i < n_recs; i++) begin
         if (recs[i][31:28] == 4'h3) begin
            exp_bytes.push_back(recs[i][7:0]);
         end else if (recs[i][31:28] == 4'h4) begin
            exp_status.push_back({recs[i][15:0], recs[i][20], recs[i][16]});
         end
      end
   endtask

   always @(negedge clk) begin
      if (rst_n && out_valid && out_ready) begin
         if (exp_bytes.size() == 0) begin
            $display("Output byte %h at %0t ns came after every expected byte.", out_byte, $time);
            report_failure();
         end else begin
            check_value(32'(out_byte), 32'(exp_bytes.pop_front()), "output byte");
         end
      end
      if (rst_n && status_valid) begin
         if (exp_status.size() == 0) begin
            $display("A frame status at %0t ns came after every expected status.", $time);
            report_failure();
         end else begin
            exp_st = exp_status.pop_front();
            check_value(32'(status.byte_count), 32'(exp_st[17:2]), "frame byte count");
            check_value(32'(status.err_dist), 32'(exp_st[1]), "frame err_dist");
            check_value(32'(status.err_limit), 32'(exp_st[0]), "frame err_limit");
            stat_seen++;
         end
      end
   end

   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles.", wd_cycles);
      report_failure();
   end

   initial begin
      int pass;
      int idx;
      clk         = 1'b0;
      rst_n       = 1'b0;
      token_valid = 1'b0;
      token       = '0;
      out_ready   = 1'b1;
      frame_limit = '0;
      gap         = 1'b0;
      stalls_on   = 1'b0;
      lfsr_state  = 32'h28b6_90c9;
      foreach (recs[i]) recs[i] = '0;
      $readmemh("test/lz_decomp_input.txt", recs);
      n_recs = 0;
      while (n_recs < MAX_RECS && recs[n_recs][31:28] != 4'h0) begin
         n_recs++;
      end
      wd_cycles = 2 * (n_recs * 40 + 16);
      // the first pass runs stall free, the second repeats it under random stalls.
      for (pass = 0; pass < 2; pass++) begin
         stalls_on = (pass == 1);
         load_expected();
         stat_seen   = 0;
         stat_target = 0;
         rst_n       = 1'b0;
         repeat (8) step_cycle();
         rst_n = 1'b1;
         for (idx = 0; idx < n_recs; idx++) begin
            case (recs[idx][31:28])
               4'h1: begin
                  while (stat_seen < stat_target) begin
                     step_cycle();  // the framer reads the limit on a frame's first byte.
                  end
                  frame_limit = recs[idx][15:0];
               end
               4'h2: send_token(recs[idx]);
               4'h4: stat_target++;
               default: ;
            endcase
         end
         while (exp_bytes.size() != 0 || exp_status.size() != 0) begin
            step_cycle();
         end
         repeat (8) step_cycle();  // a stray byte or status would show up here.
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire
